//--- vlog.f
riscv_ctrl_pkg.sv
alu_op_decode.sv
mem_branch_decode.sv
system_decode.sv
control_decode.sv
decode_stage.sv
decode_checker.sv
tb_decode_stage.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f vlog.f --top-module tb_decode_stage -o tb_decode_stage
./obj_dir/tb_decode_stage | tee sim.log

if grep -q "^RESULT: PASS$" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed, see sim.log"
    exit 1
fi

//--- tb_decode_stage.sv
`timescale 1ns/1ps
`default_nettype none

module tb_decode_stage
    import riscv_ctrl_pkg::*;
();

    localparam int CLK_PERIOD   = 8;
    localparam int RESET_CYCLES = 5;
    localparam int NUM_ALU      = 4 * 8 * 128;
    localparam int NUM_SWEEP    = 128 * 8 * 4;
    localparam int NUM_RANDOM   = 1024;
    localparam int NUM_VECTORS  = NUM_ALU + NUM_SWEEP + NUM_RANDOM;
    // one idle cycle follows every eighth vector and the mid-run reset adds two
    localparam int NUM_CYCLES   = NUM_VECTORS + NUM_VECTORS / 8 + RESET_CYCLES + 2 + 4;
    localparam int WATCHDOG_NS  = NUM_CYCLES * CLK_PERIOD + 200;

    logic               clk;
    logic               rst;
    logic               instr_valid;
    logic [INSTR_W-1:0] instr;
    logic               ctrl_valid;
    ctrl_t              ctrl;

    ctrl_t              exp_ctrl;
    logic               exp_valid;
    logic [INSTR_W-1:0] exp_instr;
    int                 checks_done;
    int                 sent;
    integer             seed;

    decode_stage DUT (
        .clk         (clk),
        .rst         (rst),
        .instr_valid (instr_valid),
        .instr       (instr),
        .ctrl_valid  (ctrl_valid),
        .ctrl        (ctrl)
    );

    bind decode_stage decode_checker u_decode_checker (
        .clk         (clk),
        .rst         (rst),
        .instr_valid (instr_valid),
        .ctrl_valid  (ctrl_valid),
        .ctrl        (ctrl)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired before the test sequence finished");
        $display("RESULT: FAIL");
        $fatal(1);
    end

    function automatic logic [INSTR_W-1:0] make_instr(input logic [OPCODE_W-1:0] opc,
                                                      input logic [FUNCT3_W-1:0] f3,
                                                      input logic [FUNCT7_W-1:0] f7,
                                                      input logic [INSTR_W-1:0]  fill);
        logic [INSTR_W-1:0] w;
        w        = fill;
        w[6:0]   = opc;
        w[14:12] = f3;
        w[31:25] = f7;
        return w;
    endfunction

    function automatic logic [OPCODE_W-1:0] alu_class(input logic [1:0] idx);
        case (idx)
            2'd0:    return OPC_OP;
            2'd1:    return OPC_OP_32;
            2'd2:    return OPC_OP_IMM;
            default: return OPC_OP_IMM_32;
        endcase
    endfunction

    function automatic width_e access_width(input logic [1:0] size);
        case (size)
            2'd0:    return W_BYTE;
            2'd1:    return W_HALF;
            2'd2:    return W_WORD;
            default: return W_DOUBLE;
        endcase
    endfunction

    function automatic ctrl_t expected_ctrl(input logic [INSTR_W-1:0] word);
        logic [OPCODE_W-1:0] opc;
        logic [FUNCT3_W-1:0] f3;
        logic [FUNCT7_W-1:0] f7;
        logic [FUNCT7_W-1:0] f7_eff;
        logic                is_reg;
        logic                is_word;
        logic                ok;
        ctrl_t               c;
        opc     = word[6:0];
        f3      = word[14:12];
        f7      = word[31:25];
        c       = CTRL_RESET;
        ok      = 1'b1;
        is_reg  = (opc == OPC_OP) || (opc == OPC_OP_32);
        is_word = (opc == OPC_OP_32) || (opc == OPC_OP_IMM_32);
        // rv64 immediate shifts borrow instr[25] as shamt[5]
        f7_eff  = (opc == OPC_OP_IMM) ? {f7[6:1], 1'b0} : f7;
        case (opc)
            OPC_OP, OPC_OP_32, OPC_OP_IMM, OPC_OP_IMM_32: begin
                c.reg_write = 1'b1;
                c.b_src     = is_reg ? B_RS2 : B_IMM;
                c.width     = is_word ? W_WORD : W_DOUBLE;
                case (f3)
                    F3_ADD_SUB: begin
                        c.alu_op = (is_reg && f7_eff == F7_ALT) ? ALU_SUB : ALU_ADD;
                        ok       = !is_reg || f7_eff == F7_BASE || f7_eff == F7_ALT;
                    end
                    F3_SLL: begin
                        c.alu_op = ALU_SLL;
                        ok       = (f7_eff == F7_BASE);
                    end
                    F3_SLT, F3_SLTU: begin
                        c.alu_op = (f3 == F3_SLT) ? ALU_SLT : ALU_SLTU;
                        ok       = !is_reg || f7_eff == F7_BASE;
                    end
                    F3_SRL_SRA: begin
                        c.alu_op = (f7_eff == F7_ALT) ? ALU_SRA : ALU_SRL;
                        ok       = (f7_eff == F7_BASE) || (f7_eff == F7_ALT);
                    end
                    default: begin
                        // xor, or and and have no word forms
                        c.alu_op = (f3 == F3_XOR) ? ALU_XOR : (f3 == F3_OR) ? ALU_OR : ALU_AND;
                        ok       = !is_word && (!is_reg || f7_eff == F7_BASE);
                    end
                endcase
            end
            OPC_LOAD: begin
                c.mem_read  = 1'b1;
                c.reg_write = 1'b1;
                c.wb_src    = WB_MEM;
                c.b_src     = B_IMM;
                if (f3 == 3'b111) begin
                    ok = 1'b0;
                end else begin
                    c.width = access_width(f3[1:0]);
                end
            end
            OPC_STORE: begin
                c.mem_write = 1'b1;
                c.b_src     = B_IMM;
                if (f3[2]) begin
                    ok = 1'b0;
                end else begin
                    c.width = access_width(f3[1:0]);
                end
            end
            OPC_BRANCH: begin
                c.width = W_DOUBLE;
                case (f3)
                    F3_BEQ:  c.branch = BR_BEQ;
                    F3_BNE:  c.branch = BR_BNE;
                    F3_BLT:  c.branch = BR_BLT;
                    F3_BGE:  c.branch = BR_BGE;
                    F3_BLTU: c.branch = BR_BLTU;
                    F3_BGEU: c.branch = BR_BGEU;
                    default: ok = 1'b0;
                endcase
            end
            OPC_JAL: begin
                c.reg_write = 1'b1;
                c.wb_src    = WB_PC_LINK;
                c.branch    = BR_JAL;
                c.width     = W_DOUBLE;
            end
            OPC_JALR: begin
                c.reg_write = 1'b1;
                c.wb_src    = WB_PC_LINK;
                c.b_src     = B_IMM;
                c.alu_op    = ALU_JALR;
                c.branch    = BR_JALR;
                c.width     = W_DOUBLE;
            end
            OPC_LUI: begin
                c.reg_write = 1'b1;
                c.b_src     = B_IMM;
                c.alu_op    = ALU_COPY_B;
                c.width     = W_DOUBLE;
            end
            OPC_AUIPC: begin
                c.reg_write = 1'b1;
                c.a_src     = A_PC;
                c.b_src     = B_IMM;
                c.width     = W_DOUBLE;
            end
            OPC_SYSTEM: begin
                c.reg_write = 1'b1;
                c.wb_src    = WB_CSR;
                c.width     = W_WORD;
                if (f3 == F3_PRIV) begin
                    c.reg_write = 1'b0;
                    c.trap      = (f7 == F7_MRET) ? TRAP_MRET : TRAP_ECALL;
                end else if (f3 == 3'b100) begin
                    ok = 1'b0;
                end else begin
                    c.csr_we = 1'b1;
                    case (f3[1:0])
                        2'b01: begin
                            // csrrwi routes its operand through the rs2 select
                            c.csr_src = CSR_ZIMM;
                            c.b_src   = f3[2] ? B_RS2 : B_RS1;
                        end
                        2'b10: begin
                            c.alu_op = ALU_OR;
                            c.a_src  = A_CSR;
                            c.b_src  = f3[2] ? B_ZIMM : B_RS1;
                        end
                        default: begin
                            c.alu_op = ALU_AND;
                            c.a_src  = A_CSR;
                            c.b_src  = f3[2] ? B_ZIMM : B_RS1;
                            c.b_neg  = 1'b1;
                        end
                    endcase
                end
            end
            default: begin
                ok = 1'b0;
            end
        endcase
        c.illegal = !ok;
        if (!ok) begin
            c.mem_read  = 1'b0;
            c.mem_write = 1'b0;
            c.reg_write = 1'b0;
            c.csr_we    = 1'b0;
        end
        return c;
    endfunction

    // the register output lags the input by one cycle, so check before driving
    task automatic check_outputs();
        assert (ctrl_valid === exp_valid) else begin
            $display("[FAIL] ctrl_valid: got 0x%h, expected 0x%h", ctrl_valid, exp_valid);
            $display("RESULT: FAIL");
            $fatal(1);
        end
        assert (ctrl === exp_ctrl) else begin
            $display("[FAIL] ctrl: got 0x%h, expected 0x%h, instr 0x%h",
                     ctrl, exp_ctrl, exp_instr);
            $display("RESULT: FAIL");
            $fatal(1);
        end
        if (exp_valid) begin
            checks_done++;
        end
    endtask

    task automatic apply_cycle(input logic valid, input logic [INSTR_W-1:0] word);
        @(negedge clk);
        check_outputs();
        instr_valid = valid;
        instr       = word;
        exp_valid   = valid;
        if (valid) begin
            exp_ctrl  = expected_ctrl(word);
            exp_instr = word;
        end
    endtask

    // a valid instruction presented during reset must not load
    task automatic apply_reset(input logic [INSTR_W-1:0] word);
        @(negedge clk);
        check_outputs();
        rst         = 1'b1;
        instr_valid = 1'b1;
        instr       = word;
        exp_valid   = 1'b0;
        exp_ctrl    = CTRL_RESET;
        exp_instr   = word;
        @(negedge clk);
        check_outputs();
        rst         = 1'b0;
        instr_valid = 1'b0;
    endtask

    task automatic send(input logic [INSTR_W-1:0] word);
        logic [INSTR_W-1:0] filler;
        apply_cycle(1'b1, word);
        sent++;
        if (sent % 8 == 0) begin
            filler = $random(seed);
            apply_cycle(1'b0, filler);
        end
    endtask

    initial begin
        logic [INSTR_W-1:0]  r;
        logic [FUNCT7_W-1:0] f7v;
        seed        = 32'h9379_bdea;
        rst         = 1'b1;
        instr_valid = 1'b0;
        instr       = '0;
        exp_ctrl    = CTRL_RESET;
        exp_valid   = 1'b0;
        exp_instr   = '0;
        checks_done = 0;
        sent        = 0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // every funct3/funct7 pair of the four arithmetic classes
        for (int c = 0; c < 4; c++) begin
            for (int f3 = 0; f3 < 8; f3++) begin
                for (int f7 = 0; f7 < 128; f7++) begin
                    r = $random(seed);
                    send(make_instr(alu_class(c[1:0]), f3[2:0], f7[6:0], r));
                end
            end
        end

        // all opcodes and funct3 codes, with the funct7 values that matter
        for (int opc = 0; opc < 128; opc++) begin
            for (int f3 = 0; f3 < 8; f3++) begin
                for (int k = 0; k < 4; k++) begin
                    r = $random(seed);
                    case (k)
                        0:       f7v = F7_MRET;
                        1:       f7v = F7_ALT;
                        2:       f7v = F7_BASE;
                        default: f7v = r[31:25];
                    endcase
                    send(make_instr(opc[6:0], f3[2:0], f7v, r));
                end
            end
        end

        // reset in mid run while the register holds a decoded word
        r = $random(seed);
        apply_reset(make_instr(OPC_LUI, 3'b000, 7'b0000000, r));

        for (int i = 0; i < NUM_RANDOM; i++) begin
            r = $random(seed);
            send(r);
        end
        apply_cycle(1'b0, '0);

        if (checks_done == NUM_VECTORS) begin
            $display("RESULT: PASS");
            $finish;
        end else begin
            $display("only %0d of %0d vectors reached the output check",
                     checks_done, NUM_VECTORS);
            $display("RESULT: FAIL");
            $fatal(1);
        end
    end

endmodule

`default_nettype wire

//--- decode_checker.sv
`timescale 1ns/1ps
`default_nettype none

module decode_checker
    import riscv_ctrl_pkg::*;
(
    input logic  clk,
    input logic  rst,
    input logic  instr_valid,
    input logic  ctrl_valid,
    input ctrl_t ctrl
);

    logic enable_any;

    assign enable_any = ctrl.mem_read || ctrl.mem_write || ctrl.reg_write || ctrl.csr_we;

    // one cycle from instruction strobe to control strobe
    valid_delay: assert property (@(posedge clk) disable iff (rst)
        !$past(rst) |-> (ctrl_valid == $past(instr_valid)))
        else $error("ctrl_valid is not instr_valid delayed by one cycle");

    reset_state: assert property (@(posedge clk)
        $past(rst) |-> (!ctrl_valid && ctrl == CTRL_RESET))
        else $error("control register not cleared by reset");

    // the register only loads on a valid instruction
    hold_idle: assert property (@(posedge clk) disable iff (rst)
        (!$past(rst) && !$past(instr_valid)) |-> $stable(ctrl))
        else $error("ctrl changed while no instruction was presented");

    illegal_quiet: assert property (@(posedge clk) disable iff (rst)
        ctrl.illegal |-> !enable_any)
        else $error("illegal instruction left an enable set");

endmodule

`default_nettype wire

//--- decode_stage.sv
`timescale 1ns/1ps
`default_nettype none

module decode_stage
    import riscv_ctrl_pkg::*;
(
    input  logic               clk,
    input  logic               rst,
    input  logic               instr_valid,
    input  logic [INSTR_W-1:0] instr,
    output logic               ctrl_valid,
    output ctrl_t              ctrl
);

    ctrl_t ctrl_next;

    control_decode u_control_decode (
        .instr (instr),
        .ctrl  (ctrl_next)
    );

    // id boundary register, the word holds while no instruction arrives
    always_ff @(posedge clk) begin
        if (rst) begin
            ctrl_valid <= 1'b0;
            ctrl       <= CTRL_RESET;
        end else begin
            ctrl_valid <= instr_valid;
            if (instr_valid) begin
                ctrl <= ctrl_next;
            end
        end
    end

endmodule

`default_nettype wire

//--- control_decode.sv
`timescale 1ns/1ps
`default_nettype none

module control_decode
    import riscv_ctrl_pkg::*;
(
    input  logic [INSTR_W-1:0] instr,
    output ctrl_t              ctrl
);

    opcode_e             op_class;
    logic [FUNCT3_W-1:0] funct3;
    logic [FUNCT7_W-1:0] funct7;
    alu_op_e             alu_op;
    logic                alu_legal;
    width_e              mem_width;
    branch_e             mem_branch;
    logic                mem_legal;
    ctrl_t               sys;
    logic                sys_legal;
    logic                known;
    logic                sub_legal;

    assign op_class = opcode_e'(instr[OPCODE_W-1:0]);
    assign funct3   = instr[14:12];
    assign funct7   = instr[31:25];

    alu_op_decode u_alu_op_decode (
        .op_class (op_class),
        .funct3   (funct3),
        .funct7   (funct7),
        .alu_op   (alu_op),
        .legal    (alu_legal)
    );

    mem_branch_decode u_mem_branch_decode (
        .op_class (op_class),
        .funct3   (funct3),
        .width    (mem_width),
        .branch   (mem_branch),
        .legal    (mem_legal)
    );

    system_decode u_system_decode (
        .funct3 (funct3),
        .funct7 (funct7),
        .sys    (sys),
        .legal  (sys_legal)
    );

    always_comb begin
        ctrl      = CTRL_RESET;
        known     = 1'b1;
        sub_legal = 1'b1;
        case (op_class)
            OPC_OP, OPC_OP_32, OPC_OP_IMM, OPC_OP_IMM_32: begin
                ctrl.reg_write = 1'b1;
                ctrl.alu_op    = alu_op;
                ctrl.b_src     = (op_class == OPC_OP || op_class == OPC_OP_32) ? B_RS2 : B_IMM;
                ctrl.width     = (op_class == OPC_OP || op_class == OPC_OP_IMM) ? W_DOUBLE : W_WORD;
                sub_legal      = alu_legal;
            end
            OPC_LOAD: begin
                ctrl.mem_read  = 1'b1;
                ctrl.reg_write = 1'b1;
                ctrl.wb_src    = WB_MEM;
                ctrl.b_src     = B_IMM;
                ctrl.width     = mem_width;
                sub_legal      = mem_legal;
            end
            OPC_STORE: begin
                ctrl.mem_write = 1'b1;
                ctrl.b_src     = B_IMM;
                ctrl.width     = mem_width;
                sub_legal      = mem_legal;
            end
            OPC_BRANCH: begin
                ctrl.branch = mem_branch;
                ctrl.width  = W_DOUBLE;
                sub_legal   = mem_legal;
            end
            OPC_JAL: begin
                ctrl.reg_write = 1'b1;
                ctrl.wb_src    = WB_PC_LINK;
                ctrl.branch    = BR_JAL;
                ctrl.width     = W_DOUBLE;
            end
            OPC_JALR: begin
                ctrl.reg_write = 1'b1;
                ctrl.wb_src    = WB_PC_LINK;
                ctrl.b_src     = B_IMM;
                ctrl.alu_op    = ALU_JALR;
                ctrl.branch    = BR_JALR;
                ctrl.width     = W_DOUBLE;
            end
            OPC_LUI: begin
                ctrl.reg_write = 1'b1;
                ctrl.b_src     = B_IMM;
                ctrl.alu_op    = ALU_COPY_B;
                ctrl.width     = W_DOUBLE;
            end
            OPC_AUIPC: begin
                ctrl.reg_write = 1'b1;
                ctrl.a_src     = A_PC;
                ctrl.b_src     = B_IMM;
                ctrl.width     = W_DOUBLE;
            end
            OPC_SYSTEM: begin
                ctrl      = sys;
                sub_legal = sys_legal;
            end
            default: begin
                known = 1'b0;
            end
        endcase

        // an illegal instruction must not change any architectural state
        ctrl.illegal = !known || !sub_legal;
        if (ctrl.illegal) begin
            ctrl.mem_read  = 1'b0;
            ctrl.mem_write = 1'b0;
            ctrl.reg_write = 1'b0;
            ctrl.csr_we    = 1'b0;
        end
    end

endmodule

`default_nettype wire

//--- system_decode.sv
`timescale 1ns/1ps
`default_nettype none

module system_decode
    import riscv_ctrl_pkg::*;
(
    input  logic [FUNCT3_W-1:0] funct3,
    input  logic [FUNCT7_W-1:0] funct7,
    output ctrl_t               sys,
    output logic                legal
);

    always_comb begin
        sys           = CTRL_RESET;
        sys.reg_write = 1'b1;
        sys.wb_src    = WB_CSR;
        sys.width     = W_WORD;
        legal         = 1'b1;
        case (funct3)
            F3_PRIV: begin
                // ebreak folds into the ecall trap code
                sys.reg_write = 1'b0;
                sys.trap      = (funct7 == F7_MRET) ? TRAP_MRET : TRAP_ECALL;
            end
            F3_CSRRW: begin
                sys.csr_we  = 1'b1;
                sys.csr_src = CSR_ZIMM;
                sys.alu_op  = ALU_ADD;
                sys.b_src   = B_RS1;
            end
            F3_CSRRWI: begin
                sys.csr_we  = 1'b1;
                sys.csr_src = CSR_ZIMM;
                sys.alu_op  = ALU_ADD;
                sys.b_src   = B_RS2;
            end
            F3_CSRRS: begin
                sys.csr_we = 1'b1;
                sys.alu_op = ALU_OR;
                sys.a_src  = A_CSR;
                sys.b_src  = B_RS1;
            end
            F3_CSRRSI: begin
                sys.csr_we = 1'b1;
                sys.alu_op = ALU_OR;
                sys.a_src  = A_CSR;
                sys.b_src  = B_ZIMM;
            end
            // clear forms AND the csr with the inverted operand
            F3_CSRRC: begin
                sys.csr_we = 1'b1;
                sys.alu_op = ALU_AND;
                sys.a_src  = A_CSR;
                sys.b_src  = B_RS1;
                sys.b_neg  = 1'b1;
            end
            F3_CSRRCI: begin
                sys.csr_we = 1'b1;
                sys.alu_op = ALU_AND;
                sys.a_src  = A_CSR;
                sys.b_src  = B_ZIMM;
                sys.b_neg  = 1'b1;
            end
            default: begin
                legal = 1'b0;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- mem_branch_decode.sv
`timescale 1ns/1ps
`default_nettype none

module mem_branch_decode
    import riscv_ctrl_pkg::*;
(
    input  opcode_e             op_class,
    input  logic [FUNCT3_W-1:0] funct3,
    output width_e              width,
    output branch_e             branch,
    output logic                legal
);

    always_comb begin
        width  = W_BYTE;
        branch = BR_NONE;
        legal  = 1'b1;
        case (op_class)
            OPC_LOAD: begin
                // unsigned loads share the signed access width
                case (funct3)
                    F3_LB, F3_LBU: width = W_BYTE;
                    F3_LH, F3_LHU: width = W_HALF;
                    F3_LW, F3_LWU: width = W_WORD;
                    F3_LD:         width = W_DOUBLE;
                    default:       legal = 1'b0;
                endcase
            end
            OPC_STORE: begin
                case (funct3)
                    F3_SB:   width = W_BYTE;
                    F3_SH:   width = W_HALF;
                    F3_SW:   width = W_WORD;
                    F3_SD:   width = W_DOUBLE;
                    default: legal = 1'b0;
                endcase
            end
            OPC_BRANCH: begin
                case (funct3)
                    F3_BEQ:  branch = BR_BEQ;
                    F3_BNE:  branch = BR_BNE;
                    F3_BLT:  branch = BR_BLT;
                    F3_BGE:  branch = BR_BGE;
                    F3_BLTU: branch = BR_BLTU;
                    F3_BGEU: branch = BR_BGEU;
                    default: legal = 1'b0;
                endcase
            end
            default: begin
                legal = 1'b1;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- alu_op_decode.sv
`timescale 1ns/1ps
`default_nettype none

module alu_op_decode
    import riscv_ctrl_pkg::*;
(
    input  opcode_e             op_class,
    input  logic [FUNCT3_W-1:0] funct3,
    input  logic [FUNCT7_W-1:0] funct7,
    output alu_op_e             alu_op,
    output logic                legal
);

    logic                reg_form;
    logic                word_form;
    logic [FUNCT7_W-1:0] f7_chk;
    logic                f7_base;
    logic                f7_alt;

    assign reg_form  = (op_class == OPC_OP) || (op_class == OPC_OP_32);
    assign word_form = (op_class == OPC_OP_32) || (op_class == OPC_OP_IMM_32);

    // low funct7 bit is shamt[5] for the 64-bit immediate shifts
    assign f7_chk  = (op_class == OPC_OP_IMM) ? (funct7 & F7_SHAMT_MASK) : funct7;
    assign f7_base = (f7_chk == F7_BASE);
    assign f7_alt  = (f7_chk == F7_ALT);

    always_comb begin
        alu_op = ALU_ADD;
        legal  = 1'b1;
        case (funct3)
            F3_ADD_SUB: begin
                // addi has no sub form, its funct7 bits are immediate
                if (reg_form && f7_alt) begin
                    alu_op = ALU_SUB;
                end
                legal = !reg_form || f7_base || f7_alt;
            end
            F3_SLL: begin
                alu_op = ALU_SLL;
                legal  = f7_base;
            end
            F3_SLT: begin
                alu_op = ALU_SLT;
                legal  = !reg_form || f7_base;
            end
            F3_SLTU: begin
                alu_op = ALU_SLTU;
                legal  = !reg_form || f7_base;
            end
            F3_XOR: begin
                alu_op = ALU_XOR;
                legal  = !word_form && (!reg_form || f7_base);
            end
            F3_SRL_SRA: begin
                alu_op = f7_alt ? ALU_SRA : ALU_SRL;
                legal  = f7_base || f7_alt;
            end
            F3_OR: begin
                alu_op = ALU_OR;
                legal  = !word_form && (!reg_form || f7_base);
            end
            F3_AND: begin
                alu_op = ALU_AND;
                legal  = !word_form && (!reg_form || f7_base);
            end
            default: begin
                legal = 1'b0;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- riscv_ctrl_pkg.sv
`default_nettype none

package riscv_ctrl_pkg;

    localparam int XLEN     = 64;
    localparam int INSTR_W  = 32;
    localparam int OPCODE_W = 7;
    localparam int FUNCT3_W = 3;
    localparam int FUNCT7_W = 7;

    // shamt is 6 bits on rv64, so immediate shifts lend instr[25] to it
    localparam int SHAMT_W = $clog2(XLEN);
    localparam logic [FUNCT7_W-1:0] F7_SHAMT_MASK = 7'h7f << (SHAMT_W - 5);

    typedef enum logic [OPCODE_W-1:0] {
        OPC_OP        = 7'b0110011,
        OPC_OP_32     = 7'b0111011,
        OPC_OP_IMM    = 7'b0010011,
        OPC_OP_IMM_32 = 7'b0011011,
        OPC_LOAD      = 7'b0000011,
        OPC_STORE     = 7'b0100011,
        OPC_BRANCH    = 7'b1100011,
        OPC_JAL       = 7'b1101111,
        OPC_JALR      = 7'b1100111,
        OPC_LUI       = 7'b0110111,
        OPC_AUIPC     = 7'b0010111,
        OPC_SYSTEM    = 7'b1110011
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD    = 4'd0,
        ALU_SUB    = 4'd1,
        ALU_SLL    = 4'd2,
        ALU_SLT    = 4'd3,
        ALU_SLTU   = 4'd4,
        ALU_XOR    = 4'd5,
        ALU_SRL    = 4'd6,
        ALU_SRA    = 4'd7,
        ALU_OR     = 4'd8,
        ALU_AND    = 4'd9,
        ALU_JALR   = 4'd10,
        ALU_COPY_B = 4'd11
    } alu_op_e;

    // arithmetic
    localparam logic [FUNCT3_W-1:0] F3_ADD_SUB = 3'b000;
    localparam logic [FUNCT3_W-1:0] F3_SLL     = 3'b001;
    localparam logic [FUNCT3_W-1:0] F3_SLT     = 3'b010;
    localparam logic [FUNCT3_W-1:0] F3_SLTU    = 3'b011;
    localparam logic [FUNCT3_W-1:0] F3_XOR     = 3'b100;
    localparam logic [FUNCT3_W-1:0] F3_SRL_SRA = 3'b101;
    localparam logic [FUNCT3_W-1:0] F3_OR      = 3'b110;
    localparam logic [FUNCT3_W-1:0] F3_AND     = 3'b111;

    // branches
    localparam logic [FUNCT3_W-1:0] F3_BEQ  = 3'b000;
    localparam logic [FUNCT3_W-1:0] F3_BNE  = 3'b001;
    localparam logic [FUNCT3_W-1:0] F3_BLT  = 3'b100;
    localparam logic [FUNCT3_W-1:0] F3_BGE  = 3'b101;
    localparam logic [FUNCT3_W-1:0] F3_BLTU = 3'b110;
    localparam logic [FUNCT3_W-1:0] F3_BGEU = 3'b111;

    // loads and stores
    localparam logic [FUNCT3_W-1:0] F3_LB  = 3'b000;
    localparam logic [FUNCT3_W-1:0] F3_LH  = 3'b001;
    localparam logic [FUNCT3_W-1:0] F3_LW  = 3'b010;
    localparam logic [FUNCT3_W-1:0] F3_LD  = 3'b011;
    localparam logic [FUNCT3_W-1:0] F3_LBU = 3'b100;
    localparam logic [FUNCT3_W-1:0] F3_LHU = 3'b101;
    localparam logic [FUNCT3_W-1:0] F3_LWU = 3'b110;
    localparam logic [FUNCT3_W-1:0] F3_SB  = 3'b000;
    localparam logic [FUNCT3_W-1:0] F3_SH  = 3'b001;
    localparam logic [FUNCT3_W-1:0] F3_SW  = 3'b010;
    localparam logic [FUNCT3_W-1:0] F3_SD  = 3'b011;

    // system
    localparam logic [FUNCT3_W-1:0] F3_PRIV   = 3'b000;
    localparam logic [FUNCT3_W-1:0] F3_CSRRW  = 3'b001;
    localparam logic [FUNCT3_W-1:0] F3_CSRRS  = 3'b010;
    localparam logic [FUNCT3_W-1:0] F3_CSRRC  = 3'b011;
    localparam logic [FUNCT3_W-1:0] F3_CSRRWI = 3'b101;
    localparam logic [FUNCT3_W-1:0] F3_CSRRSI = 3'b110;
    localparam logic [FUNCT3_W-1:0] F3_CSRRCI = 3'b111;

    localparam logic [FUNCT7_W-1:0] F7_BASE = 7'b0000000;
    localparam logic [FUNCT7_W-1:0] F7_ALT  = 7'b0100000;
    localparam logic [FUNCT7_W-1:0] F7_MRET = 7'b0011000;

    typedef enum logic [1:0] {A_RS1 = 2'd0, A_PC = 2'd1, A_CSR = 2'd2} a_src_e;

    typedef enum logic [1:0] {B_RS2 = 2'd0, B_IMM = 2'd1, B_RS1 = 2'd2, B_ZIMM = 2'd3} b_src_e;

    typedef enum logic [2:0] {
        CSR_ALU_RES = 3'd0,
        CSR_RS1     = 3'd1,
        CSR_ZIMM    = 3'd2,
        CSR_ZERO    = 3'd3
    } csr_src_e;

    typedef enum logic [1:0] {WB_ALU = 2'd0, WB_MEM = 2'd1, WB_PC_LINK = 2'd2, WB_CSR = 2'd3} wb_src_e;

    typedef enum logic [1:0] {TRAP_NONE = 2'd0, TRAP_ECALL = 2'd1, TRAP_MRET = 2'd3} trap_e;

    typedef enum logic [3:0] {
        BR_NONE = 4'd0,
        BR_JAL  = 4'd1,
        BR_JALR = 4'd2,
        BR_BEQ  = 4'd3,
        BR_BNE  = 4'd4,
        BR_BLT  = 4'd5,
        BR_BGE  = 4'd6,
        BR_BLTU = 4'd7,
        BR_BGEU = 4'd8
    } branch_e;

    typedef enum logic [1:0] {W_BYTE = 2'd0, W_HALF = 2'd1, W_WORD = 2'd2, W_DOUBLE = 2'd3} width_e;

    typedef struct packed {
        logic     mem_read;
        logic     mem_write;
        logic     reg_write;
        wb_src_e  wb_src;
        a_src_e   a_src;
        b_src_e   b_src;
        logic     b_neg;
        alu_op_e  alu_op;
        logic     csr_we;
        csr_src_e csr_src;
        trap_e    trap;
        branch_e  branch;
        width_e   width;
        logic     illegal;
    } ctrl_t;

    localparam ctrl_t CTRL_RESET = '{
        mem_read:  1'b0,
        mem_write: 1'b0,
        reg_write: 1'b0,
        wb_src:    WB_ALU,
        a_src:     A_RS1,
        b_src:     B_RS2,
        b_neg:     1'b0,
        alu_op:    ALU_ADD,
        csr_we:    1'b0,
        csr_src:   CSR_ALU_RES,
        trap:      TRAP_NONE,
        branch:    BR_NONE,
        width:     W_BYTE,
        illegal:   1'b0
    };

endpackage

`default_nettype wire
